// File: source/subbank_pkg.sv
package subbank_pkg;

  // ==========================================================================
  // Memory geometry
  // ==========================================================================

  // Total word width in bits that is split evenly across the subbanks
  localparam int WIDTH = 64;

  // Number of words in the backing array
  localparam int ELS = 256;

  // Number of independently enabled slices of one word
  localparam int NUM_SUBBANK = 4;

  // Width of one subbank as derived from the word width
  localparam int SUBBANK_WIDTH = WIDTH / NUM_SUBBANK;

  // One mask bit covers one byte of a subbank
  localparam int MASK_WIDTH = SUBBANK_WIDTH / 8;

  // Address width needed to reach every word
  localparam int ADDR_WIDTH = $clog2(ELS);

  // When set, each subbank keeps its last read value until it is read again
  localparam bit LATCH_LAST_READ = 1'b1;

  // ==========================================================================
  // Vector types
  // ==========================================================================

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One bit per subbank, used for the valid vector and the read enables
  typedef logic [NUM_SUBBANK-1:0] subbank_vec_t;

  typedef logic [SUBBANK_WIDTH-1:0] subbank_data_t;
  typedef logic [MASK_WIDTH-1:0] subbank_mask_t;

  // Subbank 0 sits in the low bits of the word and of the mask
  typedef logic [WIDTH-1:0] word_data_t;
  typedef logic [NUM_SUBBANK*MASK_WIDTH-1:0] word_mask_t;

endpackage

// File: source/mem_cmd_if.sv
`timescale 1ns/100ps

// One memory command per cycle plus the read data coming back
interface mem_cmd_if import subbank_pkg::*; ();

  // Per-subbank valid; any high bit makes the cycle a command
  subbank_vec_t v;

  // Direction shared by every valid subbank, high for write
  logic w;

  word_mask_t w_mask;
  word_data_t data;
  addr_t addr;

  // Read data as seen after the hold stage
  word_data_t rdata;

  // The requester issues commands and samples the read data
  modport requester (
    output v, w, w_mask, data, addr,
    input  rdata
  );

  // The memory takes commands and returns the read data
  modport memory (
    input  v, w, w_mask, data, addr,
    output rdata
  );

endinterface

// File: source/byte_mask_sram.sv
`timescale 1ns/100ps

// Single-port behavioral RAM, one full word wide, with a byte write mask.
// Reads are registered, so data appears on the edge after the command.
module byte_mask_sram import subbank_pkg::*; (
  input  logic       clk_i,
  input  logic       en_i,
  input  logic       w_i,
  input  addr_t      addr_i,
  input  word_data_t data_i,
  input  word_mask_t w_mask_i,
  output word_data_t data_o
);

  // ==========================================================================
  // Storage
  // ==========================================================================

  // Contents are undefined until a location has been written
  word_data_t mem [ELS];

  // ==========================================================================
  // Write port
  // ==========================================================================

  // Only bytes with a high mask bit are updated, the rest keep old contents.
  // The wrapper has already cleared the mask bits of subbanks that are not
  // valid, so this array does not need to know about subbanks at all
  always_ff @(posedge clk_i) begin : write_port
    if (en_i && w_i) begin
      for (int b = 0; b < $bits(word_mask_t); b++) begin
        if (w_mask_i[b]) begin
          mem[addr_i][b*8 +: 8] <= data_i[b*8 +: 8];
        end
      end
    end
  end

  // ==========================================================================
  // Read port
  // ==========================================================================

  // The whole word is read whenever the array is enabled without a write.
  // The output register is left alone on writes and idle cycles; the hold
  // stage downstream decides which cycles of this output are meaningful
  always_ff @(posedge clk_i) begin : read_port
    if (en_i && !w_i) begin
      data_o <= mem[addr_i];
    end
  end

  // An enabled access must fall inside the array
  a_addr_in_range: assert property (
    @(posedge clk_i) en_i |-> (addr_i < ELS)
  ) else $error("byte_mask_sram address %0d out of range", addr_i);

endmodule

// File: source/read_hold.sv
`timescale 1ns/100ps

// Keeps the last read value of one subbank.
// In the cycle right after a read the array data passes straight through and
// is captured at the same time. Later cycles show the captured copy.
module read_hold import subbank_pkg::*; (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          rd_en_i,
  input  subbank_data_t data_i,
  output subbank_data_t data_o
);

  // High in the cycle where the array output belongs to this subbank
  logic rd_en_r;

  // Copy of the most recent read data for this subbank
  subbank_data_t hold_r;

  // Read enable delayed to line up with the registered array output
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_en_r <= 1'b0;
    end else begin
      rd_en_r <= rd_en_i;
    end
  end

  // Capture the fresh array data while it is valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_r <= '0;
    end else if (rd_en_r) begin
      hold_r <= data_i;
    end
  end

  // Bypass on the read-return cycle, otherwise show the held copy
  assign data_o = rd_en_r ? data_i : hold_r;

  // Outside a read-return cycle the subbank output must not move, whatever
  // the array or the other subbanks are doing
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (reset_i) !rd_en_r |-> $stable(data_o)
  ) else $error("read_hold output changed without a read");

endmodule

// File: source/subbanked_sram.sv
`timescale 1ns/100ps

// Subbanked memory built on one full-width byte-masked array.
// All subbanks share the address and the direction of a cycle; the valid
// vector picks which subbanks take part.
module subbanked_sram import subbank_pkg::*; (
  input logic      clk_i,
  input logic      reset_i,
  mem_cmd_if.memory cmd
);

  // ==========================================================================
  // Command decode
  // ==========================================================================

  // The array runs in any cycle where at least one subbank is valid
  logic array_en;

  // Byte mask with the bits of non-valid subbanks forced low
  word_mask_t w_mask_gated;

  // Read enable of each subbank that is valid in a cycle without a write
  subbank_vec_t rd_en;

  // Raw registered output of the backing array
  word_data_t array_rdata;

  // Read data after the per-subbank hold logic
  word_data_t rdata_int;

  assign array_en = |cmd.v;

  for (genvar i = 0; i < NUM_SUBBANK; i++) begin : g_subbank
    // This subbank's slice of the incoming mask qualified by its valid bit
    subbank_mask_t sub_mask;
    subbank_data_t sub_rdata;

    assign sub_mask = cmd.w_mask[i*MASK_WIDTH +: MASK_WIDTH] & {MASK_WIDTH{cmd.v[i]}};
    assign w_mask_gated[i*MASK_WIDTH +: MASK_WIDTH] = sub_mask;
    assign rd_en[i] = cmd.v[i] & ~cmd.w;

    if (LATCH_LAST_READ) begin : g_llr
      // Each subbank holds its own last read so that partial reads do not
      // disturb the subbanks left out of them
      read_hold u_read_hold (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rd_en_i (rd_en[i]),
        .data_i  (array_rdata[i*SUBBANK_WIDTH +: SUBBANK_WIDTH]),
        .data_o  (sub_rdata)
      );
    end else begin : g_no_llr
      // Without holding, the array output is presented as is
      assign sub_rdata = array_rdata[i*SUBBANK_WIDTH +: SUBBANK_WIDTH];
    end

    assign rdata_int[i*SUBBANK_WIDTH +: SUBBANK_WIDTH] = sub_rdata;
  end

  assign cmd.rdata = rdata_int;

  // ==========================================================================
  // Backing array
  // ==========================================================================

  byte_mask_sram u_array (
    .clk_i    (clk_i),
    .en_i     (array_en),
    .w_i      (cmd.w),
    .addr_i   (cmd.addr),
    .data_i   (cmd.data),
    .w_mask_i (w_mask_gated),
    .data_o   (array_rdata)
  );

  // ==========================================================================
  // Checks
  // ==========================================================================

  // Geometry must split into whole subbanks of whole bytes
  if (WIDTH % NUM_SUBBANK != 0) begin : g_bad_split
    $error("WIDTH must be a multiple of NUM_SUBBANK");
  end

  if (((WIDTH & (WIDTH - 1)) != 0) || ((ELS & (ELS - 1)) != 0)) begin : g_bad_pow2
    $error("WIDTH and ELS must be powers of two");
  end

  // A command needs a known address and direction, otherwise the array and
  // every hold stage would pick up garbage
  a_cmd_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (|cmd.v) |-> !$isunknown({cmd.addr, cmd.w})
  ) else $error("subbanked_sram command with unknown addr or w");

endmodule

// File: source/subbanked_mem_top.sv
`timescale 1ns/100ps

// Top level of the subbanked memory with plain ports.
// The ports are gathered onto the command bus and handed to the wrapper.
module subbanked_mem_top import subbank_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  subbank_vec_t v_i,
  input  logic         w_i,
  input  word_mask_t   w_mask_i,
  input  word_data_t   data_i,
  input  addr_t        addr_i,
  output word_data_t   data_o
);

  // ==========================================================================
  // Command bus
  // ==========================================================================

  // This level plays the requester side of the bus
  mem_cmd_if cmd_bus ();

  assign cmd_bus.v      = v_i;
  assign cmd_bus.w      = w_i;
  assign cmd_bus.w_mask = w_mask_i;
  assign cmd_bus.data   = data_i;
  assign cmd_bus.addr   = addr_i;

  // Read data returns one cycle after a read and then holds per subbank
  assign data_o = cmd_bus.rdata;

  // ==========================================================================
  // Memory
  // ==========================================================================

  subbanked_sram u_sram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd     (cmd_bus.memory)
  );

endmodule

// File: tests/tb_tasks.svh
// ==========================================================================
// Stimulus and checking helpers
// ==========================================================================

// Linear congruential generator with the constants from Numerical Recipes
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

task automatic check_word(input string name, input word_data_t expected,
                          input word_data_t actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  end
endtask

task automatic check_subbank(input string name, input subbank_data_t expected,
                             input subbank_data_t actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  end
endtask

// Apply one command to the model.
// Masked bytes of valid subbanks are written, and valid subbanks of a read
// take the stored word as their next output
task automatic model_update(input subbank_vec_t v, input logic w, input word_mask_t m,
                            input word_data_t d, input addr_t a);
  int k;
  for (int i = 0; i < NUM_SUBBANK; i++) begin
    for (int b = 0; b < MASK_WIDTH; b++) begin
      k = i * MASK_WIDTH + b;
      if (v[i] && w && m[k]) begin
        ref_mem[a][k*8 +: 8] = d[k*8 +: 8];
      end
    end
    if (v[i] && !w) begin
      exp_rd[i] = ref_mem[a][i*SUBBANK_WIDTH +: SUBBANK_WIDTH];
    end
  end
endtask

// Entered 1 ns after a rising edge; returns 1 ns after the edge that took
// the command, where data_o already shows the result of a read
task automatic run_cmd(input subbank_vec_t v, input logic w, input word_mask_t m,
                       input word_data_t d, input addr_t a);
  v_i      = v;
  w_i      = w;
  w_mask_i = m;
  data_i   = d;
  addr_i   = a;
  @(posedge clk_i);
  #1;
  model_update(v, w, m, d, a);
  // Back to idle so that a pause in the stimulus is not a repeated command
  v_i = '0;
  for (int i = 0; i < NUM_SUBBANK; i++) begin
    check_subbank($sformatf("data_o subbank %0d", i), exp_rd[i],
                  data_o[i*SUBBANK_WIDTH +: SUBBANK_WIDTH]);
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) run_cmd('0, 1'b0, '0, '0, '0);
endtask

// ==========================================================================
// Directed and random tests
// ==========================================================================

task automatic reset_clears_output();
  check_word("data_o after reset", '0, data_o);
endtask

task automatic full_word_readback();
  addr_t addrs [4] = '{8'h00, 8'h3c, 8'h81, 8'hff};
  word_data_t wr [4];
  foreach (addrs[n]) begin
    wr[n] = {next_rand(), next_rand()};
    run_cmd(4'hf, 1'b1, 8'hff, wr[n], addrs[n]);
  end
  // Reads in another order than the writes
  for (int n = 3; n >= 0; n--) begin
    run_cmd(4'hf, 1'b0, '0, '0, addrs[n]);
    check_word("data_o full read", wr[n], data_o);
  end
endtask

task automatic partial_mask_write();
  word_data_t old_word;
  word_data_t new_word;
  word_data_t expected;
  word_mask_t mask;
  old_word = {next_rand(), next_rand()};
  new_word = {next_rand(), next_rand()};
  mask     = 8'b1001_0110;
  // Bytes with a low mask bit keep the first word
  for (int b = 0; b < 8; b++) begin
    expected[b*8 +: 8] = mask[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
  end
  run_cmd(4'hf, 1'b1, 8'hff, old_word, 8'h42);
  run_cmd(4'hf, 1'b1, mask, new_word, 8'h42);
  run_cmd(4'hf, 1'b0, '0, '0, 8'h42);
  check_word("data_o after masked write", expected, data_o);
endtask

task automatic partial_valid_write();
  word_data_t old_word;
  word_data_t new_word;
  old_word = {next_rand(), next_rand()};
  new_word = {next_rand(), next_rand()};
  run_cmd(4'hf, 1'b1, 8'hff, old_word, 8'h17);
  // Full mask, but subbanks 1 and 3 are not valid
  run_cmd(4'b0101, 1'b1, 8'hff, new_word, 8'h17);
  run_cmd(4'hf, 1'b0, '0, '0, 8'h17);
  check_word("data_o after partial valid write",
             {old_word[63:48], new_word[47:32], old_word[31:16], new_word[15:0]}, data_o);
endtask

task automatic partial_read_hold();
  word_data_t word_a;
  word_data_t word_b;
  word_data_t word_c;
  word_data_t expected;
  word_a = {next_rand(), next_rand()};
  word_b = {next_rand(), next_rand()};
  word_c = {next_rand(), next_rand()};
  run_cmd(4'hf, 1'b1, 8'hff, word_a, 8'h20);
  run_cmd(4'hf, 1'b1, 8'hff, word_b, 8'h21);
  run_cmd(4'hf, 1'b0, '0, '0, 8'h20);
  check_word("data_o full read", word_a, data_o);
  // Only the low two subbanks move to the second word
  run_cmd(4'b0011, 1'b0, '0, '0, 8'h21);
  expected = {word_a[63:32], word_b[31:0]};
  check_word("data_o low read", expected, data_o);
  // Neither a write nor idle cycles may disturb the held output
  run_cmd(4'hf, 1'b1, 8'hff, word_c, 8'h20);
  check_word("data_o after write", expected, data_o);
  idle_cycles(3);
  check_word("data_o after idle", expected, data_o);
  run_cmd(4'b1000, 1'b0, '0, '0, 8'h20);
  expected[63:48] = word_c[63:48];
  check_word("data_o top read", expected, data_o);
  idle_cycles(1);
  check_word("data_o held", expected, data_o);
endtask

task automatic random_commands();
  logic [31:0] r;
  // Every location gets known contents first, so no read returns X
  for (int a = 0; a < ELS; a++) begin
    run_cmd(4'hf, 1'b1, 8'hff, {next_rand(), next_rand()}, addr_t'(a));
  end
  // The address comes from the high bits, whose period is long enough that
  // addresses repeat and reads meet the data of earlier random writes
  for (int n = 0; n < RANDOM_CMDS; n++) begin
    r = next_rand();
    run_cmd(r[23:20], r[19], r[15:8], {next_rand(), next_rand()}, r[31:24]);
  end
endtask

// File: tests/tb_subbanked_mem.sv
`timescale 1ns/100ps

module tb_subbanked_mem import subbank_pkg::*; ();

  // ==========================================================================
  // Run length
  // ==========================================================================

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_CMDS  = 200;

  // The random test fills the whole array before its mixed commands.
  // The directed tests need well under 64 cycles between them
  localparam int TEST_CYCLES = RESET_CYCLES + ELS + RANDOM_CMDS + 64;
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD + 200;

  // ==========================================================================
  // DUT signals
  // ==========================================================================

  logic         clk_i;
  logic         reset_i;
  subbank_vec_t v_i;
  logic         w_i;
  word_mask_t   w_mask_i;
  word_data_t   data_i;
  addr_t        addr_i;
  word_data_t   data_o;

  // Reference model of the array contents
  word_data_t ref_mem [ELS];

  // Expected data_o per subbank that only reads of that subbank change
  subbank_data_t exp_rd [NUM_SUBBANK];

  int errors;
  int checks;
  logic [31:0] lcg_state;

  subbanked_mem_top UUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (v_i),
    .w_i      (w_i),
    .w_mask_i (w_mask_i),
    .data_i   (data_i),
    .addr_i   (addr_i),
    .data_o   (data_o)
  );

  `include "tb_tasks.svh"

  // ==========================================================================
  // Clock, watchdog and test sequence
  // ==========================================================================

  initial clk_i = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Stops a run that no longer makes progress
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    reset_i   = 1'b1;
    v_i       = '0;
    w_i       = 1'b0;
    w_mask_i  = '0;
    data_i    = '0;
    addr_i    = '0;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'h5c89;
    // The hold registers clear on reset, so zero is the first expectation
    for (int i = 0; i < NUM_SUBBANK; i++) begin
      exp_rd[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    reset_clears_output();
    full_word_readback();
    partial_mask_write();
    partial_valid_write();
    partial_read_hold();
    random_commands();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/subbank_pkg.sv
source/mem_cmd_if.sv
source/byte_mask_sram.sv
source/read_hold.sv
source/subbanked_sram.sv
source/subbanked_mem_top.sv
+incdir+tests
tests/tb_subbanked_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_subbanked_mem -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation build or run error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
